// ==== files.f ====
+incdir+sim
rtl/ctrlPkg.sv
rtl/decodeStatusIf.sv
rtl/aluDecode.sv
rtl/memDecode.sv
rtl/branchDecode.sv
rtl/exceptionUnit.sv
rtl/ctrlTop.sv
sim/ctrlTb.sv

// ==== run.sh ====
#!/bin/sh
# build the decode control unit testbench and run it
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ctrlTb -f files.f -o ctrlSim \
	&& ./obj_dir/ctrlSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "testbench reported a failure"; exit 1; } || true
echo "testbench finished without failure"

// ==== sim/ctrlRef.svh ====
`ifndef CTRL_REF_SVH
`define CTRL_REF_SVH

// expected decode outputs, in the order of the ctrlTop output ports
typedef struct packed {
	logic [4:0] aluOp;
	logic [1:0] extOp;
	logic shamtSel;
	logic [1:0] dstSel;
	logic [2:0] wbSel;
	logic rfWr;
	logic dmRd;
	logic dmWr;
	logic [2:0] memSize;
	logic isBranch;
	logic [1:0] npcSel;
	logic branchFlush;
	logic exception;
	logic [4:0] excCode;
} ctrlWord;

function automatic ctrlWord ctrlRef(
	input instrWord w,
	input logic cmpNe,
	input logic [1:0] cmpSign,
	input logic ifFlush,
	input logic prevExc,
	input logic [4:0] prevExcCode,
	input logic resetting
);
	ctrlWord c;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rt;
	logic special;
	logic cond;
	logic taken;
	logic likely;
	logic regJump;
	logic jump;
	logic known;

	op = w.iType.op;
	fn = w.rType.funct;
	rt = w.iType.rt;
	special = (op == OpSpecial);
	c = '0;
	c.aluOp = AluNone;
	c.wbSel = WbAlu;
	c.memSize = MemLw;
	cond = 1'b0;
	taken = 1'b0;
	likely = 1'b0;

	// register forms write rd
	if (special) begin
		c.dstSel = DstRd;
		case (fn)
			FnAdd: c.aluOp = AluAdd;
			FnAddu: c.aluOp = AluAddu;
			FnSub: c.aluOp = AluSub;
			FnSubu: c.aluOp = AluSubu;
			FnAnd: c.aluOp = AluAnd;
			FnOr: c.aluOp = AluOr;
			FnXor: c.aluOp = AluXor;
			FnNor: c.aluOp = AluNor;
			FnSlt: c.aluOp = AluSlt;
			FnSltu: c.aluOp = AluSltu;
			FnSll, FnSllv: c.aluOp = AluSll;
			FnSrl, FnSrlv: c.aluOp = AluSrl;
			FnSra, FnSrav: c.aluOp = AluSra;
			default: ;
		endcase
		c.shamtSel = fn inside {FnSll, FnSrl, FnSra};
		c.rfWr = (c.aluOp != AluNone) || (fn == FnJalr);
		if (fn == FnJalr)
			c.wbSel = WbLink;
	end

	// immediate forms
	case (op)
		OpAddi: c.aluOp = AluAdd;
		OpAddiu: c.aluOp = AluAddu;
		OpSlti: c.aluOp = AluSlt;
		OpSltiu: c.aluOp = AluSltu;
		OpAndi: c.aluOp = AluAnd;
		OpOri: c.aluOp = AluOr;
		OpXori: c.aluOp = AluXor;
		default: ;
	endcase
	if (op inside {OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui})
		c.rfWr = 1'b1;
	if (op inside {OpAddi, OpAddiu, OpSlti, OpSltiu})
		c.extOp = ExtSign;
	if (op == OpLui) begin
		c.extOp = ExtUpper;
		c.wbSel = WbLui;
	end

	// loads and stores add a signed offset
	c.dmRd = op inside {OpLb, OpLbu, OpLh, OpLhu, OpLw};
	c.dmWr = op inside {OpSb, OpSh, OpSw};
	if (c.dmRd || c.dmWr) begin
		c.aluOp = AluAdd;
		c.extOp = ExtSign;
	end
	if (c.dmRd) begin
		c.rfWr = 1'b1;
		c.wbSel = WbMem;
	end
	case (op)
		OpLb: c.memSize = MemLb;
		OpLbu: c.memSize = MemLbu;
		OpLh: c.memSize = MemLh;
		OpLhu: c.memSize = MemLhu;
		OpSb: c.memSize = MemSb;
		OpSh: c.memSize = MemSh;
		OpSw: c.memSize = MemSw;
		default: ;
	endcase

	// link forms put the return address in ra, REGIMM links have rt[4] set
	if (op == OpJal || op == OpRegimm) begin
		c.dstSel = DstRa;
		c.wbSel = WbLink;
		c.rfWr = (op == OpJal) || (rt[4] && rt[3:2] == 2'b00);
	end

	// branch conditions
	case (op)
		OpBeq, OpBeql: begin
			cond = 1'b1;
			taken = !cmpNe;
		end
		OpBne, OpBnel: begin
			cond = 1'b1;
			taken = cmpNe;
		end
		OpBlez, OpBlezl: begin
			cond = 1'b1;
			taken = (cmpSign != SignPos);
		end
		OpBgtz, OpBgtzl: begin
			cond = 1'b1;
			taken = (cmpSign == SignPos);
		end
		// rt[0] picks GEZ over LTZ, rt[1] marks likely
		OpRegimm: begin
			cond = (rt[3:2] == 2'b00);
			taken = rt[0] ? (cmpSign != SignNeg) : (cmpSign == SignNeg);
			likely = rt[1];
		end
		default: ;
	endcase
	if (op inside {OpBeql, OpBnel, OpBlezl, OpBgtzl})
		likely = 1'b1;
	if (op inside {OpBlezl, OpBgtzl} && rt != 5'd0)
		cond = 1'b0;

	regJump = special && (fn == FnJr || fn == FnJalr);
	jump = (op == OpJ) || (op == OpJal);
	c.isBranch = cond || regJump || jump;
	if (cond && taken)
		c.npcSel = NpcBranch;
	else if (jump)
		c.npcSel = NpcJump;
	else if (regJump)
		c.npcSel = NpcReg;
	else
		c.npcSel = NpcSeq;
	c.branchFlush = cond && likely && !taken;

	// exceptions in priority order
	known = c.rfWr || c.dmWr || cond || regJump || jump ||
		(special && (fn == FnBreak || fn == FnSyscall));
	c.exception = 1'b1;
	if (prevExc)
		c.excCode = prevExcCode;
	else if (!known && !resetting && !ifFlush)
		c.excCode = ExcRi;
	else if (special && fn == FnBreak)
		c.excCode = ExcBp;
	else if (special && fn == FnSyscall)
		c.excCode = ExcSys;
	else
		c.exception = 1'b0;
	return c;
endfunction

`endif

// ==== sim/ctrlTb.sv ====
`timescale 1ns/1ps

module ctrlTb import ctrlPkg::*; ();

	`include "ctrlRef.svh"

	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 8;
	localparam int Reps = 3;
	localparam int TotalVecs = ResetCycles + 4 + 24 * Reps + 8 * Reps + 18 * 6 + 8 + 18 + 64;
	localparam int WatchdogNs = (TotalVecs + ResetCycles + 50) * ClkPeriod;

	localparam logic [5:0] AluFns [16] = '{FnAdd, FnAddu, FnSub, FnSubu, FnAnd, FnOr,
		FnXor, FnNor, FnSlt, FnSltu, FnSll, FnSrl, FnSra, FnSllv, FnSrlv, FnSrav};
	localparam logic [5:0] ImmOps [8] = '{OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi,
		OpOri, OpXori, OpLui};
	localparam logic [5:0] MemOps [8] = '{OpLb, OpLbu, OpLh, OpLhu, OpLw, OpSb, OpSh, OpSw};
	localparam logic [5:0] BrOps [8] = '{OpBeq, OpBne, OpBlez, OpBgtz, OpBeql, OpBnel,
		OpBlezl, OpBgtzl};
	localparam logic [4:0] RegimmRts [8] = '{RtBltz, RtBgez, RtBltzl, RtBgezl, RtBltzal,
		RtBgezal, RtBltzall, RtBgezall};
	// MULT, MFC0, TLBWI and TEQ
	localparam logic [31:0] DroppedWords [4] = '{32'h00850018, 32'h40086000,
		32'h42000002, 32'h00850034};

	bit clk;
	logic rst;
	instrWord instr;
	logic cmpNe;
	logic [1:0] cmpSign;
	logic ifFlush;
	logic prevExc;
	logic [4:0] prevExcCode;
	logic [4:0] aluOp;
	logic [1:0] extOp;
	logic shamtSel;
	logic [1:0] dstSel;
	logic [2:0] wbSel;
	logic rfWr;
	logic dmRd;
	logic dmWr;
	logic [2:0] memSize;
	logic isBranch;
	logic [1:0] npcSel;
	logic branchFlush;
	logic exception;
	logic [4:0] excCode;

	logic rstAtEdge;
	bit done = 1'b0;
	string testName;
	int aluErrs = 0;
	int memErrs = 0;
	int branchErrs = 0;
	int excErrs = 0;

	ctrlTop UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// the reset level the DUT's marker register saw at the last edge
	always @(posedge clk)
		rstAtEdge <= rst;

	function automatic instrWord rTypeWord(input logic [5:0] op, input logic [5:0] fn);
		instrWord w;
		w = $urandom;
		w.rType.op = op;
		w.rType.funct = fn;
		return w;
	endfunction

	function automatic instrWord iTypeWord(input logic [5:0] op);
		instrWord w;
		w = $urandom;
		w.iType.op = op;
		return w;
	endfunction

	task automatic driveVector(input string name, input instrWord w, input logic ne,
		input logic [1:0] sg, input logic fl, input logic pe, input logic [4:0] pc);
		@(posedge clk);
		testName = name;
		instr <= w;
		cmpNe <= ne;
		cmpSign <= sg;
		ifFlush <= fl;
		prevExc <= pe;
		prevExcCode <= pc;
	endtask

	// plain decode with a random comparator result
	task automatic driveInstr(input string name, input instrWord w);
		driveVector(name, w, 1'($urandom), 2'($urandom_range(0, 2)), 1'b0, 1'b0, 5'd0);
	endtask

	task automatic sweepBranch(input string name, input instrWord w);
		for (int ne = 0; ne < 2; ne++) begin
			for (int s = 0; s < 3; s++)
				driveVector(name, w, 1'(ne), 2'(s), 1'b0, 1'b0, 5'd0);
		end
	endtask

	task automatic aluCompare(input string name, input ctrlWord exp, input ctrlWord act);
		if ({exp.aluOp, exp.extOp, exp.shamtSel, exp.dstSel, exp.wbSel, exp.rfWr} !==
			{act.aluOp, act.extOp, act.shamtSel, act.dstSel, act.wbSel, act.rfWr}) begin
			aluErrs++;
			$write("error %s alu: expected op %0d ext %0d shamt %0b dst %0d wb %0d wr %0b",
				name, exp.aluOp, exp.extOp, exp.shamtSel, exp.dstSel, exp.wbSel, exp.rfWr);
			$display(", actual op %0d ext %0d shamt %0b dst %0d wb %0d wr %0b",
				act.aluOp, act.extOp, act.shamtSel, act.dstSel, act.wbSel, act.rfWr);
		end
	endtask

	task automatic memCompare(input string name, input ctrlWord exp, input ctrlWord act);
		if ({exp.dmRd, exp.dmWr, exp.memSize} !== {act.dmRd, act.dmWr, act.memSize}) begin
			memErrs++;
			$display("error %s mem: expected rd %0b wr %0b size %0d, actual rd %0b wr %0b size %0d",
				name, exp.dmRd, exp.dmWr, exp.memSize, act.dmRd, act.dmWr, act.memSize);
		end
	endtask

	task automatic branchCompare(input string name, input ctrlWord exp, input ctrlWord act);
		if ({exp.isBranch, exp.npcSel, exp.branchFlush} !==
			{act.isBranch, act.npcSel, act.branchFlush}) begin
			branchErrs++;
			$write("error %s branch: expected br %0b npc %0d flush %0b", name,
				exp.isBranch, exp.npcSel, exp.branchFlush);
			$display(", actual br %0b npc %0d flush %0b",
				act.isBranch, act.npcSel, act.branchFlush);
		end
	endtask

	task automatic excCompare(input string name, input ctrlWord exp, input ctrlWord act);
		if ({exp.exception, exp.excCode} !== {act.exception, act.excCode}) begin
			excErrs++;
			$display("error %s exception: expected exc %0b code %0d, actual exc %0b code %0d",
				name, exp.exception, exp.excCode, act.exception, act.excCode);
		end
	endtask

	// outputs settle long before the falling edge
	always @(negedge clk) begin
		ctrlWord expWord;
		ctrlWord actWord;
		if (!done) begin
			expWord = ctrlRef(instr, cmpNe, cmpSign, ifFlush, prevExc, prevExcCode,
				!rstAtEdge);
			actWord = {aluOp, extOp, shamtSel, dstSel, wbSel, rfWr, dmRd, dmWr, memSize,
				isBranch, npcSel, branchFlush, exception, excCode};
			aluCompare(testName, expWord, actWord);
			memCompare(testName, expWord, actWord);
			branchCompare(testName, expWord, actWord);
			excCompare(testName, expWord, actWord);
		end
	end

	initial begin
		instrWord w;
		void'($urandom(75770));
		rst = 1'b0;
		instr = '0;
		cmpNe = 1'b0;
		cmpSign = SignZero;
		ifFlush = 1'b0;
		prevExc = 1'b0;
		prevExcCode = 5'd0;
		testName = "init";

		// reserved words held through reset and the release
		for (int i = 0; i < ResetCycles + 4; i++) begin
			driveVector("reset", DroppedWords[i % 4], 1'b0, SignZero, 1'b0, 1'b0, 5'd0);
			if (i == ResetCycles - 1)
				rst <= 1'b1;
		end

		for (int r = 0; r < Reps; r++) begin
			for (int i = 0; i < 16; i++)
				driveInstr("aluReg", rTypeWord(OpSpecial, AluFns[i]));
			for (int i = 0; i < 8; i++)
				driveInstr("aluImm", iTypeWord(ImmOps[i]));
		end
		for (int r = 0; r < Reps; r++) begin
			for (int i = 0; i < 8; i++)
				driveInstr("mem", iTypeWord(MemOps[i]));
		end

		for (int i = 0; i < 8; i++) begin
			w = iTypeWord(BrOps[i]);
			if (BrOps[i] == OpBlezl || BrOps[i] == OpBgtzl)
				w.iType.rt = '0;
			sweepBranch("branch", w);
		end
		for (int i = 0; i < 8; i++) begin
			w = iTypeWord(OpRegimm);
			w.iType.rt = RegimmRts[i];
			sweepBranch("regimm", w);
		end
		// likely forms with a nonzero rt are not branches
		w = iTypeWord(OpBlezl);
		w.iType.rt = 5'($urandom_range(1, 31));
		sweepBranch("blezlRt", w);
		w = iTypeWord(OpBgtzl);
		w.iType.rt = 5'($urandom_range(1, 31));
		sweepBranch("bgtzlRt", w);

		for (int r = 0; r < 2; r++) begin
			driveInstr("j", iTypeWord(OpJ));
			driveInstr("jal", iTypeWord(OpJal));
			driveInstr("jr", rTypeWord(OpSpecial, FnJr));
			driveInstr("jalr", rTypeWord(OpSpecial, FnJalr));
		end

		for (int i = 0; i < 8; i++) begin
			w = $urandom;
			driveVector("prevExc", w, 1'($urandom), 2'($urandom_range(0, 2)),
				1'($urandom), 1'b1, 5'($urandom));
		end
		for (int i = 0; i < 4; i++) begin
			driveVector("dropped", DroppedWords[i], 1'b0, SignZero, 1'b0, 1'b0, 5'd0);
			driveVector("droppedFlush", DroppedWords[i], 1'b0, SignZero, 1'b1, 1'b0, 5'd0);
		end
		driveInstr("break", rTypeWord(OpSpecial, FnBreak));
		driveInstr("syscall", rTypeWord(OpSpecial, FnSyscall));

		for (int i = 0; i < 64; i++) begin
			w = $urandom;
			driveVector("random", w, 1'($urandom), 2'($urandom_range(0, 2)),
				1'($urandom), ($urandom_range(0, 7) == 0), 5'($urandom));
		end

		// last vector is checked on the falling edge before this
		@(posedge clk);
		done = 1'b1;
		$display("errors: alu %0d, mem %0d, branch %0d, exception %0d",
			aluErrs, memErrs, branchErrs, excErrs);
		if (aluErrs + memErrs + branchErrs + excErrs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("timeout: stimulus did not complete within %0d ns", WatchdogNs);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== rtl/ctrlTop.sv ====
`timescale 1ns/1ps

module ctrlTop import ctrlPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord instr,
	input logic cmpNe,
	input logic [1:0] cmpSign,
	input logic ifFlush,
	input logic prevExc,
	input logic [4:0] prevExcCode,
	output logic [4:0] aluOp,
	output logic [1:0] extOp,
	output logic shamtSel,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel,
	output logic rfWr,
	output logic dmRd,
	output logic dmWr,
	output logic [2:0] memSize,
	output logic isBranch,
	output logic [1:0] npcSel,
	output logic branchFlush,
	output logic exception,
	output logic [4:0] excCode
);

	// decoder flags for the RI check
	decodeStatusIf status ();

	aluDecode uAlu (
		.instr(instr),
		.status(status.alu),
		.aluOp(aluOp),
		.extOp(extOp),
		.shamtSel(shamtSel),
		.dstSel(dstSel),
		.wbSel(wbSel),
		.rfWr(rfWr)
	);

	memDecode uMem (
		.instr(instr),
		.status(status.mem),
		.dmRd(dmRd),
		.dmWr(dmWr),
		.memSize(memSize)
	);

	branchDecode uBranch (
		.instr(instr),
		.cmpNe(cmpNe),
		.cmpSign(cmpSign),
		.status(status.branch),
		.isBranch(isBranch),
		.npcSel(npcSel),
		.branchFlush(branchFlush)
	);

	exceptionUnit uExc (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.ifFlush(ifFlush),
		.prevExc(prevExc),
		.prevExcCode(prevExcCode),
		.status(status.exc),
		.exception(exception),
		.excCode(excCode)
	);

endmodule

// ==== rtl/exceptionUnit.sv ====
`timescale 1ns/1ps

module exceptionUnit import ctrlPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord instr,
	input logic ifFlush,
	input logic prevExc,
	input logic [4:0] prevExcCode,
	decodeStatusIf.exc status,
	output logic exception,
	output logic [4:0] excCode
);

	logic resetting;
	logic isBreak;
	logic isSyscall;
	logic recognised;

	// high for the cycle after each clock edge that saw reset
	always_ff @(posedge clk) begin
		if (!rst)
			resetting <= 1'b1;
		else
			resetting <= 1'b0;
	end

	assign isBreak = (instr.rType.op == OpSpecial) && (instr.rType.funct == FnBreak);
	assign isSyscall = (instr.rType.op == OpSpecial) && (instr.rType.funct == FnSyscall);

	assign recognised = status.rfWr | status.dmWr | status.bjOp | status.jumpOp |
		isBreak | isSyscall;

	// fetch exception first, then RI, then break, then syscall
	always_comb begin
		exception = 1'b1;
		excCode = 5'd0;
		if (prevExc)
			excCode = prevExcCode;
		else if (!recognised && !resetting && !ifFlush)
			excCode = ExcRi;
		else if (isBreak)
			excCode = ExcBp;
		else if (isSyscall)
			excCode = ExcSys;
		else
			exception = 1'b0;
	end

endmodule

// ==== rtl/branchDecode.sv ====
`timescale 1ns/1ps

module branchDecode import ctrlPkg::*; (
	input instrWord instr,
	input logic cmpNe,
	input logic [1:0] cmpSign,
	decodeStatusIf.branch status,
	output logic isBranch,
	output logic [1:0] npcSel,
	output logic branchFlush
);

	logic condBr;
	logic condOk;
	logic likely;
	logic regJump;
	logic jump;

	// conditional branches and their conditions
	always_comb begin
		condBr = 1'b0;
		condOk = 1'b0;
		likely = 1'b0;
		case (instr.rType.op)
			OpBeq, OpBeql: begin
				condBr = 1'b1;
				condOk = ~cmpNe;
				likely = (instr.rType.op == OpBeql);
			end
			OpBne, OpBnel: begin
				condBr = 1'b1;
				condOk = cmpNe;
				likely = (instr.rType.op == OpBnel);
			end
			OpBlez, OpBgtz: begin
				condBr = 1'b1;
				condOk = (instr.rType.op == OpBlez) ? (cmpSign != SignPos) :
					(cmpSign == SignPos);
			end
			// likely forms are only valid with rt zero
			OpBlezl, OpBgtzl: begin
				condBr = (instr.rType.rt == '0);
				likely = 1'b1;
				condOk = (instr.rType.op == OpBlezl) ? (cmpSign != SignPos) :
					(cmpSign == SignPos);
			end
			OpRegimm: begin
				case (instr.rType.rt)
					RtBgez, RtBgezal, RtBgezl, RtBgezall: begin
						condBr = 1'b1;
						condOk = (cmpSign != SignNeg);
					end
					RtBltz, RtBltzal, RtBltzl, RtBltzall: begin
						condBr = 1'b1;
						condOk = (cmpSign == SignNeg);
					end
					default: ;
				endcase
				likely = instr.rType.rt inside {RtBgezl, RtBgezall, RtBltzl, RtBltzall};
			end
			default: ;
		endcase
	end

	assign regJump = (instr.rType.op == OpSpecial) &&
		(instr.rType.funct inside {FnJr, FnJalr});
	assign jump = (instr.rType.op == OpJ) || (instr.rType.op == OpJal);

	assign isBranch = condBr | regJump | jump;

	always_comb begin
		if (condBr && condOk)
			npcSel = NpcBranch;
		else if (jump)
			npcSel = NpcJump;
		else if (regJump)
			npcSel = NpcReg;
		else
			npcSel = NpcSeq;
	end

	// not-taken likely branch kills its delay slot
	assign branchFlush = condBr & likely & ~condOk;

	assign status.bjOp = condBr | regJump;
	assign status.jumpOp = jump;

endmodule

// ==== rtl/memDecode.sv ====
`timescale 1ns/1ps

module memDecode import ctrlPkg::*; (
	input instrWord instr,
	decodeStatusIf.mem status,
	output logic dmRd,
	output logic dmWr,
	output logic [2:0] memSize
);

	always_comb begin
		dmRd = 1'b0;
		dmWr = 1'b0;
		// non-memory instructions fall back to word size
		memSize = MemLw;
		case (instr.iType.op)
			OpLb, OpLbu, OpLh, OpLhu, OpLw: begin
				dmRd = 1'b1;
				case (instr.iType.op)
					OpLb: memSize = MemLb;
					OpLbu: memSize = MemLbu;
					OpLh: memSize = MemLh;
					OpLhu: memSize = MemLhu;
					default: memSize = MemLw;
				endcase
			end
			OpSb, OpSh, OpSw: begin
				dmWr = 1'b1;
				case (instr.iType.op)
					OpSb: memSize = MemSb;
					OpSh: memSize = MemSh;
					default: memSize = MemSw;
				endcase
			end
			default: ;
		endcase
	end

	assign status.dmWr = dmWr;

endmodule

// ==== rtl/aluDecode.sv ====
`timescale 1ns/1ps

module aluDecode import ctrlPkg::*; (
	input instrWord instr,
	decodeStatusIf.alu status,
	output logic [4:0] aluOp,
	output logic [1:0] extOp,
	output logic shamtSel,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel,
	output logic rfWr
);

	always_comb begin
		aluOp = AluNone;
		extOp = ExtZero;
		dstSel = DstRt;
		wbSel = WbAlu;
		rfWr = 1'b0;
		case (instr.rType.op)
			OpSpecial: begin
				dstSel = DstRd;
				rfWr = 1'b1;
				case (instr.rType.funct)
					FnAdd: aluOp = AluAdd;
					FnAddu: aluOp = AluAddu;
					FnSub: aluOp = AluSub;
					FnSubu: aluOp = AluSubu;
					FnAnd: aluOp = AluAnd;
					FnOr: aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnNor: aluOp = AluNor;
					FnSlt: aluOp = AluSlt;
					FnSltu: aluOp = AluSltu;
					FnSll, FnSllv: aluOp = AluSll;
					FnSrl, FnSrlv: aluOp = AluSrl;
					FnSra, FnSrav: aluOp = AluSra;
					// return address goes to rd
					FnJalr: wbSel = WbLink;
					// JR, break, syscall and dropped functs write nothing
					default: rfWr = 1'b0;
				endcase
			end
			OpRegimm: begin
				dstSel = DstRa;
				wbSel = WbLink;
				rfWr = instr.rType.rt inside {RtBltzal, RtBgezal, RtBltzall, RtBgezall};
			end
			OpJal: begin
				dstSel = DstRa;
				wbSel = WbLink;
				rfWr = 1'b1;
			end
			OpAddi, OpAddiu, OpSlti, OpSltiu: begin
				extOp = ExtSign;
				rfWr = 1'b1;
				case (instr.rType.op)
					OpAddi: aluOp = AluAdd;
					OpAddiu: aluOp = AluAddu;
					OpSlti: aluOp = AluSlt;
					default: aluOp = AluSltu;
				endcase
			end
			OpAndi, OpOri, OpXori: begin
				rfWr = 1'b1;
				case (instr.rType.op)
					OpAndi: aluOp = AluAnd;
					OpOri: aluOp = AluOr;
					default: aluOp = AluXor;
				endcase
			end
			OpLui: begin
				extOp = ExtUpper;
				wbSel = WbLui;
				rfWr = 1'b1;
			end
			OpLb, OpLbu, OpLh, OpLhu, OpLw: begin
				aluOp = AluAdd;
				extOp = ExtSign;
				wbSel = WbMem;
				rfWr = 1'b1;
			end
			// address calculation only
			OpSb, OpSh, OpSw: begin
				aluOp = AluAdd;
				extOp = ExtSign;
			end
			default: ;
		endcase
	end

	// constant shifts take the amount from shamt
	assign shamtSel = (instr.rType.op == OpSpecial) &&
		(instr.rType.funct inside {FnSll, FnSrl, FnSra});

	assign status.rfWr = rfWr;

endmodule

// ==== rtl/decodeStatusIf.sv ====
`timescale 1ns/1ps

// per-decoder "this instruction is mine" flags
interface decodeStatusIf;
	logic rfWr;
	logic dmWr;
	logic bjOp;
	logic jumpOp;

	modport alu (
		output rfWr
	);

	modport mem (
		output dmWr
	);

	modport branch (
		output bjOp,
		output jumpOp
	);

	modport exc (
		input rfWr,
		input dmWr,
		input bjOp,
		input jumpOp
	);
endinterface

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

	// instruction field widths
	localparam int OpW = 6;
	localparam int RegW = 5;
	localparam int FunctW = 6;
	localparam int ImmW = 16;
	localparam int InstrW = 32;

	// one instruction word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [OpW-1:0] op;
			logic [RegW-1:0] rs;
			logic [RegW-1:0] rt;
			logic [RegW-1:0] rd;
			logic [RegW-1:0] shamt;
			logic [FunctW-1:0] funct;
		} rType;
		struct packed {
			logic [OpW-1:0] op;
			logic [RegW-1:0] rs;
			logic [RegW-1:0] rt;
			logic [ImmW-1:0] imm;
		} iType;
	} instrWord;

	// major opcodes
	localparam logic [OpW-1:0] OpSpecial = 6'b000000;
	localparam logic [OpW-1:0] OpRegimm = 6'b000001;
	localparam logic [OpW-1:0] OpJ = 6'b000010;
	localparam logic [OpW-1:0] OpJal = 6'b000011;
	localparam logic [OpW-1:0] OpBeq = 6'b000100;
	localparam logic [OpW-1:0] OpBne = 6'b000101;
	localparam logic [OpW-1:0] OpBlez = 6'b000110;
	localparam logic [OpW-1:0] OpBgtz = 6'b000111;
	localparam logic [OpW-1:0] OpAddi = 6'b001000;
	localparam logic [OpW-1:0] OpAddiu = 6'b001001;
	localparam logic [OpW-1:0] OpSlti = 6'b001010;
	localparam logic [OpW-1:0] OpSltiu = 6'b001011;
	localparam logic [OpW-1:0] OpAndi = 6'b001100;
	localparam logic [OpW-1:0] OpOri = 6'b001101;
	localparam logic [OpW-1:0] OpXori = 6'b001110;
	localparam logic [OpW-1:0] OpLui = 6'b001111;
	localparam logic [OpW-1:0] OpBeql = 6'b010100;
	localparam logic [OpW-1:0] OpBnel = 6'b010101;
	localparam logic [OpW-1:0] OpBlezl = 6'b010110;
	localparam logic [OpW-1:0] OpBgtzl = 6'b010111;
	localparam logic [OpW-1:0] OpLb = 6'b100000;
	localparam logic [OpW-1:0] OpLh = 6'b100001;
	localparam logic [OpW-1:0] OpLw = 6'b100011;
	localparam logic [OpW-1:0] OpLbu = 6'b100100;
	localparam logic [OpW-1:0] OpLhu = 6'b100101;
	localparam logic [OpW-1:0] OpSb = 6'b101000;
	localparam logic [OpW-1:0] OpSh = 6'b101001;
	localparam logic [OpW-1:0] OpSw = 6'b101011;

	// SPECIAL function codes
	localparam logic [FunctW-1:0] FnSll = 6'b000000;
	localparam logic [FunctW-1:0] FnSrl = 6'b000010;
	localparam logic [FunctW-1:0] FnSra = 6'b000011;
	localparam logic [FunctW-1:0] FnSllv = 6'b000100;
	localparam logic [FunctW-1:0] FnSrlv = 6'b000110;
	localparam logic [FunctW-1:0] FnSrav = 6'b000111;
	localparam logic [FunctW-1:0] FnJr = 6'b001000;
	localparam logic [FunctW-1:0] FnJalr = 6'b001001;
	localparam logic [FunctW-1:0] FnSyscall = 6'b001100;
	localparam logic [FunctW-1:0] FnBreak = 6'b001101;
	localparam logic [FunctW-1:0] FnAdd = 6'b100000;
	localparam logic [FunctW-1:0] FnAddu = 6'b100001;
	localparam logic [FunctW-1:0] FnSub = 6'b100010;
	localparam logic [FunctW-1:0] FnSubu = 6'b100011;
	localparam logic [FunctW-1:0] FnAnd = 6'b100100;
	localparam logic [FunctW-1:0] FnOr = 6'b100101;
	localparam logic [FunctW-1:0] FnXor = 6'b100110;
	localparam logic [FunctW-1:0] FnNor = 6'b100111;
	localparam logic [FunctW-1:0] FnSlt = 6'b101010;
	localparam logic [FunctW-1:0] FnSltu = 6'b101011;

	// REGIMM branches, selected by rt
	localparam logic [RegW-1:0] RtBltz = 5'b00000;
	localparam logic [RegW-1:0] RtBgez = 5'b00001;
	localparam logic [RegW-1:0] RtBltzl = 5'b00010;
	localparam logic [RegW-1:0] RtBgezl = 5'b00011;
	localparam logic [RegW-1:0] RtBltzal = 5'b10000;
	localparam logic [RegW-1:0] RtBgezal = 5'b10001;
	localparam logic [RegW-1:0] RtBltzall = 5'b10010;
	localparam logic [RegW-1:0] RtBgezall = 5'b10011;

	// ALU operations
	localparam logic [4:0] AluAdd = 5'd0;
	localparam logic [4:0] AluSub = 5'd1;
	localparam logic [4:0] AluOr = 5'd2;
	localparam logic [4:0] AluAnd = 5'd3;
	localparam logic [4:0] AluNor = 5'd4;
	localparam logic [4:0] AluXor = 5'd5;
	localparam logic [4:0] AluSll = 5'd6;
	localparam logic [4:0] AluSrl = 5'd7;
	localparam logic [4:0] AluSra = 5'd8;
	localparam logic [4:0] AluSlt = 5'd9;
	localparam logic [4:0] AluSltu = 5'd10;
	localparam logic [4:0] AluAddu = 5'd12;
	localparam logic [4:0] AluSubu = 5'd16;
	localparam logic [4:0] AluNone = 5'd31;

	// immediate extension
	localparam logic [1:0] ExtZero = 2'd0;
	localparam logic [1:0] ExtSign = 2'd1;
	localparam logic [1:0] ExtUpper = 2'd2;

	// writeback source
	localparam logic [2:0] WbLui = 3'd1;
	localparam logic [2:0] WbAlu = 3'd2;
	localparam logic [2:0] WbLink = 3'd3;
	localparam logic [2:0] WbMem = 3'd4;

	// destination register
	localparam logic [1:0] DstRt = 2'd0;
	localparam logic [1:0] DstRd = 2'd1;
	localparam logic [1:0] DstRa = 2'd2;

	// next PC source
	localparam logic [1:0] NpcSeq = 2'd0;
	localparam logic [1:0] NpcBranch = 2'd1;
	localparam logic [1:0] NpcJump = 2'd2;
	localparam logic [1:0] NpcReg = 2'd3;

	// data memory access size and signedness
	localparam logic [2:0] MemSb = 3'd0;
	localparam logic [2:0] MemSh = 3'd1;
	localparam logic [2:0] MemSw = 3'd2;
	localparam logic [2:0] MemLbu = 3'd3;
	localparam logic [2:0] MemLb = 3'd4;
	localparam logic [2:0] MemLhu = 3'd5;
	localparam logic [2:0] MemLh = 3'd6;
	localparam logic [2:0] MemLw = 3'd7;

	// sign of the rs operand from the comparator
	localparam logic [1:0] SignZero = 2'd0;
	localparam logic [1:0] SignPos = 2'd1;
	localparam logic [1:0] SignNeg = 2'd2;

	// exception codes raised in decode
	localparam logic [4:0] ExcSys = 5'd8;
	localparam logic [4:0] ExcBp = 5'd9;
	localparam logic [4:0] ExcRi = 5'd10;

endpackage
